// File: logic/coef_loader.sv
module coef_loader
	import conv_pkg::*;
#(
	parameter int CHANNELS = 4
)
(
	input logic clk,
	input logic rst,
	input logic coef_load,
	input coef_word_t coef_data,
	output logic coef_read,
	output coord_t coef_addr,
	output logic coef_ready,
	output bias_t [CHANNELS-1:0] biases,
	output weight_t [CHANNELS-1:0][TAPS-1:0] weights
);

	localparam coord_t LAST_CH = coord_t'(CHANNELS - 1);
	localparam coord_t LAST_TAP = coord_t'(TAPS - 1);

	load_state_e state;
	coord_t ch_cnt;
	coord_t tap_cnt;
	logic last_ch;

	assign coef_read = (state != LOAD_IDLE);
	assign last_ch = (ch_cnt == LAST_CH);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= LOAD_IDLE;
			coef_addr <= '0;
			ch_cnt <= '0;
			tap_cnt <= '0;
			coef_ready <= 1'b0;
		end
		else
		begin
			case (state)
				LOAD_IDLE:
				begin
					if (coef_load)
					begin
						state <= LOAD_BIAS;
						coef_addr <= '0;
						ch_cnt <= '0;
						tap_cnt <= '0;
						coef_ready <= 1'b0;
					end
				end
				LOAD_BIAS:
				begin
					coef_addr <= coef_addr + 1'b1;
					ch_cnt <= last_ch ? '0 : ch_cnt + 1'b1;
					if (last_ch)
					begin
						state <= LOAD_WEIGHT;
					end
				end
				LOAD_WEIGHT:
				begin
					coef_addr <= coef_addr + 1'b1;
					ch_cnt <= last_ch ? '0 : ch_cnt + 1'b1;
					// weights are stored tap major, channel minor
					if (last_ch)
					begin
						tap_cnt <= tap_cnt + 1'b1;
						if (tap_cnt == LAST_TAP)
						begin
							state <= LOAD_IDLE;
							coef_ready <= 1'b1;
						end
					end
				end
				default:
				begin
					state <= LOAD_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == LOAD_BIAS)
		begin
			biases[ch_cnt] <= bias_t'(coef_data);
		end
		if (state == LOAD_WEIGHT)
		begin
			// low byte only
			weights[ch_cnt][tap_cnt] <= weight_t'(coef_data[7:0]);
		end
	end

	addr_in_map: assert property (@(posedge clk) disable iff (rst)
		coef_read |-> coef_addr < CHANNELS * (1 + TAPS));

endmodule

// File: logic/conv_layer.sv
module conv_layer
	import conv_pkg::*;
#(
	parameter int IMG_W = 6,
	parameter int IMG_H = 5,
	parameter int CHANNELS = 4
)
(
	input logic clk,
	input logic rst,
	input logic coef_load,
	input coef_word_t coef_data,
	input logic frame_start,
	input pixel_t pixel_in,
	output logic coef_read,
	output coord_t coef_addr,
	output logic coef_ready,
	output logic pixel_read,
	output coord_t read_row,
	output coord_t read_col,
	output logic out_valid,
	output coord_t out_row,
	output coord_t out_col,
	output acc_t [CHANNELS-1:0] out_data,
	output logic frame_done
);

	window_t window;
	pos_t scan_pos;
	pos_t out_pos;
	bias_t [CHANNELS-1:0] biases;
	weight_t [CHANNELS-1:0][TAPS-1:0] weights;

	scan_ctrl #(
		.IMG_W(IMG_W),
		.IMG_H(IMG_H)
	) u_scan_ctrl (
		.clk(clk),
		.rst(rst),
		.frame_start(frame_start),
		.coef_ready(coef_ready),
		.pixel_read(pixel_read),
		.read_row(read_row),
		.read_col(read_col),
		.scan_pos(scan_pos)
	);

	line_window #(
		.IMG_W(IMG_W)
	) u_line_window (
		.clk(clk),
		.rst(rst),
		.pixel_in(pixel_in),
		.pixel_read(pixel_read),
		.window(window)
	);

	coef_loader #(
		.CHANNELS(CHANNELS)
	) u_coef_loader (
		.clk(clk),
		.rst(rst),
		.coef_load(coef_load),
		.coef_data(coef_data),
		.coef_read(coef_read),
		.coef_addr(coef_addr),
		.coef_ready(coef_ready),
		.biases(biases),
		.weights(weights)
	);

	conv_mac #(
		.IMG_W(IMG_W),
		.IMG_H(IMG_H),
		.CHANNELS(CHANNELS)
	) u_conv_mac (
		.clk(clk),
		.rst(rst),
		.window(window),
		.weights(weights),
		.biases(biases),
		.scan_pos(scan_pos),
		.out_pos(out_pos),
		.out_data(out_data),
		.frame_done(frame_done)
	);

	assign out_valid = out_pos.valid;
	assign out_row = out_pos.row;
	assign out_col = out_pos.col;

endmodule

// File: logic/conv_mac.sv
module conv_mac
	import conv_pkg::*;
#(
	parameter int IMG_W = 6,
	parameter int IMG_H = 5,
	parameter int CHANNELS = 4
)
(
	input logic clk,
	input logic rst,
	input window_t window,
	input weight_t [CHANNELS-1:0][TAPS-1:0] weights,
	input bias_t [CHANNELS-1:0] biases,
	input pos_t scan_pos,
	output pos_t out_pos,
	output acc_t [CHANNELS-1:0] out_data,
	output logic frame_done
);

	localparam coord_t LAST_ROW = coord_t'(IMG_H - KERNEL);
	localparam coord_t LAST_COL = coord_t'(IMG_W - KERNEL);

	prod_t [CHANNELS-1:0][TAPS-1:0] prod;
	acc_t [CHANNELS-1:0] sum;
	pos_t mid_pos;

	// stage one, one multiplier per tap and channel
	always_ff @(posedge clk)
	begin
		for (int ch = 0; ch < CHANNELS; ch++)
		begin
			for (int t = 0; t < TAPS; t++)
			begin
				prod[ch][t] <= prod_t'(window[t]) * prod_t'(weights[ch][t]);
			end
		end
	end

	// sum of the nine products plus bias
	always_comb
	begin
		for (int ch = 0; ch < CHANNELS; ch++)
		begin
			sum[ch] = acc_t'(biases[ch]);
			for (int t = 0; t < TAPS; t++)
			begin
				sum[ch] = sum[ch] + acc_t'(prod[ch][t]);
			end
		end
	end

	// stage two
	always_ff @(posedge clk)
	begin
		out_data <= sum;
	end

	// position travels next to its data
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			mid_pos <= '0;
			out_pos <= '0;
		end
		else
		begin
			mid_pos <= scan_pos;
			out_pos <= mid_pos;
		end
	end

	// last window of the frame
	assign frame_done = out_pos.valid && (out_pos.row == LAST_ROW) &&
		(out_pos.col == LAST_COL);

	out_in_frame: assert property (@(posedge clk) disable iff (rst)
		out_pos.valid |-> (out_pos.row <= LAST_ROW) && (out_pos.col <= LAST_COL));

endmodule

// File: logic/conv_pkg.sv
package conv_pkg;

	// window geometry
	localparam int KERNEL = 3;
	localparam int TAPS = KERNEL * KERNEL;

	// newest pixel of the window sits in the bottom right corner
	localparam int TAP_NEWEST = TAPS - 1;

	typedef logic signed [7:0] pixel_t;
	typedef logic signed [7:0] weight_t;
	typedef logic signed [15:0] bias_t;

	// full product of one pixel and one weight
	typedef logic signed [15:0] prod_t;

	// bias plus nine products
	typedef logic signed [20:0] acc_t;

	typedef logic [15:0] coef_word_t;
	typedef logic [7:0] coord_t;

	// tap = kernel row * 3 + kernel column, row 0 on top
	typedef pixel_t [TAPS-1:0] window_t;

	typedef struct packed
	{
		logic valid;
		coord_t row;
		coord_t col;
	} pos_t;

	typedef enum logic
	{
		SCAN_IDLE,
		SCAN_RUN
	} scan_state_e;

	typedef enum logic [1:0]
	{
		LOAD_IDLE,
		LOAD_BIAS,
		LOAD_WEIGHT
	} load_state_e;

endpackage

// File: logic/line_window.sv
module line_window
	import conv_pkg::*;
#(
	parameter int IMG_W = 6
)
(
	input logic clk,
	input logic rst,
	input pixel_t pixel_in,
	input logic pixel_read,
	output window_t window
);

	// a row register plus its line buffer spans one image row
	localparam int LB_DEPTH = IMG_W - KERNEL;

	pixel_t line_buf [KERNEL-1][LB_DEPTH];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			window <= '0;
		end
		else if (pixel_read)
		begin
			// each row register shifts left by one column
			for (int kr = 0; kr < KERNEL; kr++)
			begin
				for (int kc = 0; kc < KERNEL - 1; kc++)
				begin
					window[kr * KERNEL + kc] <= window[kr * KERNEL + kc + 1];
				end
			end
			// upper rows are refilled from the line buffers
			for (int kr = 0; kr < KERNEL - 1; kr++)
			begin
				window[kr * KERNEL + KERNEL - 1] <= line_buf[kr][LB_DEPTH-1];
			end
			window[TAP_NEWEST] <= pixel_in;
		end
	end

	// buffer kr takes what falls out of the row below it
	always_ff @(posedge clk)
	begin
		if (pixel_read)
		begin
			for (int b = 0; b < KERNEL - 1; b++)
			begin
				line_buf[b][0] <= window[(b + 1) * KERNEL];
				for (int i = 1; i < LB_DEPTH; i++)
				begin
					line_buf[b][i] <= line_buf[b][i-1];
				end
			end
		end
	end

endmodule

// File: logic/scan_ctrl.sv
module scan_ctrl
	import conv_pkg::*;
#(
	parameter int IMG_W = 6,
	parameter int IMG_H = 5
)
(
	input logic clk,
	input logic rst,
	input logic frame_start,
	input logic coef_ready,
	output logic pixel_read,
	output coord_t read_row,
	output coord_t read_col,
	output pos_t scan_pos
);

	localparam coord_t LAST_COL = coord_t'(IMG_W - 1);
	localparam coord_t LAST_ROW = coord_t'(IMG_H - 1);

	scan_state_e state;
	logic last_col;
	logic last_pixel;
	logic window_full;

	assign pixel_read = (state == SCAN_RUN);
	assign last_col = (read_col == LAST_COL);
	assign last_pixel = last_col && (read_row == LAST_ROW);

	// window is complete once two rows and two columns lie behind the read
	assign window_full = (read_row >= coord_t'(KERNEL - 1)) &&
		(read_col >= coord_t'(KERNEL - 1));

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= SCAN_IDLE;
			read_row <= '0;
			read_col <= '0;
		end
		else
		begin
			case (state)
				SCAN_IDLE:
				begin
					// coefficients must be in place before a frame
					if (frame_start && coef_ready)
					begin
						state <= SCAN_RUN;
						read_row <= '0;
						read_col <= '0;
					end
				end
				SCAN_RUN:
				begin
					if (last_pixel)
					begin
						state <= SCAN_IDLE;
						read_row <= '0;
						read_col <= '0;
					end
					else if (last_col)
					begin
						read_row <= read_row + 1'b1;
						read_col <= '0;
					end
					else
					begin
						read_col <= read_col + 1'b1;
					end
				end
				default:
				begin
					state <= SCAN_IDLE;
				end
			endcase
		end
	end

	// position of the window's top left corner
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			scan_pos <= '0;
		end
		else
		begin
			scan_pos.valid <= pixel_read && window_full;
			scan_pos.row <= read_row - coord_t'(KERNEL - 1);
			scan_pos.col <= read_col - coord_t'(KERNEL - 1);
		end
	end

	read_in_frame: assert property (@(posedge clk) disable iff (rst)
		pixel_read |-> (read_col < IMG_W) && (read_row < IMG_H));

endmodule

// File: run.sh
#!/bin/sh
# compile and run the conv layer testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module conv_tb -o conv_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

output=$(./obj_dir/conv_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1

// File: src.f
logic/conv_pkg.sv
logic/scan_ctrl.sv
logic/line_window.sv
logic/coef_loader.sv
logic/conv_mac.sv
logic/conv_layer.sv
testbench/clock_gen.sv
testbench/conv_tb.sv

// File: testbench/clock_gen.sv
module clock_gen
#(
	parameter int PERIOD = 8,
	parameter int RESET_CYCLES = 5
)
(
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// release lands just after an edge, like the other inputs
	initial
	begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
	end

endmodule

// File: testbench/conv_tb.sv
module conv_tb
	import conv_pkg::*;
;

	localparam int IMG_W = 6;
	localparam int IMG_H = 5;
	localparam int CHANNELS = 4;
	localparam int NUM_COEF = CHANNELS * (1 + TAPS);
	localparam int NUM_PIX = IMG_W * IMG_H;
	localparam int OUT_W = IMG_W - 2;
	localparam int NUM_OUT = (IMG_H - 2) * OUT_W;
	localparam int LOAD_TIMEOUT = 10;
	localparam int FRAME_TIMEOUT = IMG_W * IMG_H + 20;
	localparam int N_CASES = 6;

	typedef enum logic [1:0] {PIX_CONST, PIX_RAMP, PIX_RANDOM} pix_pattern_e;
	typedef enum logic {COEF_CONST, COEF_RANDOM} coef_pattern_e;

	typedef struct packed
	{
		pix_pattern_e pix;
		coef_pattern_e coef;
		pixel_t pix_value;
		weight_t weight;
		bias_t bias;
		int expected;
	} frame_case_t;

	logic clk;
	logic rst;
	logic coef_load;
	coef_word_t coef_data;
	logic frame_start;
	pixel_t pixel_in;
	logic coef_read;
	coord_t coef_addr;
	logic coef_ready;
	logic pixel_read;
	coord_t read_row;
	coord_t read_col;
	logic out_valid;
	coord_t out_row;
	coord_t out_col;
	acc_t [CHANNELS-1:0] out_data;
	logic frame_done;

	pixel_t img [IMG_H][IMG_W];
	coef_word_t coef_mem [NUM_COEF];
	frame_case_t cases [N_CASES];
	logic [31:0] lfsr;
	int mismatches;
	int timeouts;

	clock_gen u_clock_gen (
		.clk(clk),
		.rst(rst)
	);

	conv_layer #(
		.IMG_W(IMG_W),
		.IMG_H(IMG_H),
		.CHANNELS(CHANNELS)
	) DUT (
		.clk(clk),
		.rst(rst),
		.coef_load(coef_load),
		.coef_data(coef_data),
		.frame_start(frame_start),
		.pixel_in(pixel_in),
		.coef_read(coef_read),
		.coef_addr(coef_addr),
		.coef_ready(coef_ready),
		.pixel_read(pixel_read),
		.read_row(read_row),
		.read_col(read_col),
		.out_valid(out_valid),
		.out_row(out_row),
		.out_col(out_col),
		.out_data(out_data),
		.frame_done(frame_done)
	);

	// both memories answer the address of the current cycle
	always @(posedge clk)
	begin
		#1;
		if (int'(read_row) < IMG_H && int'(read_col) < IMG_W)
			pixel_in = img[read_row][read_col];
		coef_data = (int'(coef_addr) < NUM_COEF) ? coef_mem[coef_addr] : '0;
	end

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	// bias plus the 3x3 weighted neighborhood read from the memory map
	function automatic int ref_conv(input int r, input int c, input int ch);
		int acc;
		int w;
		acc = int'($signed(coef_mem[ch]));
		for (int kr = 0; kr < KERNEL; kr++)
		begin
			for (int kc = 0; kc < KERNEL; kc++)
			begin
				w = int'($signed(coef_mem[CHANNELS + (kr * KERNEL + kc) * CHANNELS + ch][7:0]));
				acc = acc + w * int'(img[r + kr][c + kc]);
			end
		end
		return acc;
	endfunction

	task automatic log_mismatch(input string msg);
		mismatches++;
		$display("FAILED at time %0t: %s", $time, msg);
	endtask

	task automatic log_timeout(input string what);
		timeouts++;
		$display("timeout at time %0t while waiting for %s", $time, what);
	endtask

	task automatic step_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic load_coefs(input frame_case_t fc);
		int cycles;
		int count;
		for (int ch = 0; ch < CHANNELS; ch++)
			coef_mem[ch] = (fc.coef == COEF_CONST) ? coef_word_t'(fc.bias) : take_bits(16);
		// high byte of a weight word is junk on purpose
		for (int i = CHANNELS; i < NUM_COEF; i++)
			coef_mem[i] = (fc.coef == COEF_CONST) ? {8'h5a, fc.weight} : take_bits(16);
		coef_load = 1'b1;
		step_cycle();
		coef_load = 1'b0;
		cycles = 0;
		while (!coef_read && cycles < LOAD_TIMEOUT)
		begin
			step_cycle();
			cycles++;
		end
		assert (cycles < LOAD_TIMEOUT) else log_timeout("coef_read");
		count = 0;
		while (coef_read && count < NUM_COEF + 4)
		begin
			assert (int'(coef_addr) == count)
			else log_mismatch($sformatf("coef_addr %0d, expected %0d", coef_addr, count));
			assert (!coef_ready) else log_mismatch("coef_ready high during a load");
			count++;
			step_cycle();
		end
		assert (count == NUM_COEF)
		else log_mismatch($sformatf("%0d coefficient reads, expected %0d", count, NUM_COEF));
		repeat (5)
		begin
			assert (coef_ready) else log_mismatch("coef_ready not held after load");
			step_cycle();
		end
	endtask

	task automatic run_frame(input frame_case_t fc);
		int cycles;
		int n_out;
		int n_reads;
		int done_seen;
		int exp_r;
		int exp_c;
		int ref_val;
		for (int r = 0; r < IMG_H; r++)
		begin
			for (int c = 0; c < IMG_W; c++)
			begin
				case (fc.pix)
					PIX_CONST: img[r][c] = fc.pix_value;
					PIX_RAMP: img[r][c] = pixel_t'(r * IMG_W + c - 15);
					default: img[r][c] = pixel_t'(take_bits(8));
				endcase
			end
		end
		frame_start = 1'b1;
		step_cycle();
		frame_start = 1'b0;
		cycles = 0;
		n_out = 0;
		n_reads = 0;
		done_seen = 0;
		while (done_seen == 0 && cycles < FRAME_TIMEOUT)
		begin
			// pixel reads walk the image in raster order
			if (pixel_read)
			begin
				assert (int'(read_row) == n_reads / IMG_W &&
					int'(read_col) == n_reads % IMG_W)
				else log_mismatch($sformatf("read at (%0d,%0d), expected (%0d,%0d)",
					read_row, read_col, n_reads / IMG_W, n_reads % IMG_W));
				n_reads++;
			end
			if (out_valid)
			begin
				exp_r = n_out / OUT_W;
				exp_c = n_out % OUT_W;
				assert (int'(out_row) == exp_r && int'(out_col) == exp_c)
				else log_mismatch($sformatf("output at (%0d,%0d), expected (%0d,%0d)",
					out_row, out_col, exp_r, exp_c));
				for (int ch = 0; ch < CHANNELS; ch++)
				begin
					ref_val = ref_conv(exp_r, exp_c, ch);
					assert (int'($signed(out_data[ch])) == ref_val)
					else log_mismatch($sformatf("(%0d,%0d) ch %0d gave %0d, expected %0d",
						exp_r, exp_c, ch, $signed(out_data[ch]), ref_val));
					if (fc.pix == PIX_CONST && fc.coef == COEF_CONST)
						assert (int'($signed(out_data[ch])) == fc.expected)
						else log_mismatch($sformatf("ch %0d gave %0d, table says %0d",
							ch, $signed(out_data[ch]), fc.expected));
				end
				assert (frame_done == (n_out == NUM_OUT - 1))
				else log_mismatch($sformatf("frame_done %0b at output %0d", frame_done, n_out));
				n_out++;
			end
			else
				assert (!frame_done) else log_mismatch("frame_done without out_valid");
			if (frame_done)
				done_seen++;
			step_cycle();
			cycles++;
		end
		assert (cycles < FRAME_TIMEOUT) else log_timeout("frame_done");
		assert (n_out == NUM_OUT)
		else log_mismatch($sformatf("%0d outputs, expected %0d", n_out, NUM_OUT));
		assert (n_reads == NUM_PIX)
		else log_mismatch($sformatf("%0d pixel reads, expected %0d", n_reads, NUM_PIX));
		repeat (4)
		begin
			assert (!out_valid && !frame_done && !pixel_read)
			else log_mismatch("activity after frame_done");
			step_cycle();
		end
	endtask

	initial
	begin
		int cycles;
		coef_load = 1'b0;
		coef_data = '0;
		frame_start = 1'b0;
		pixel_in = '0;
		lfsr = 32'h6c5d_d34a;
		mismatches = 0;
		timeouts = 0;
		cases[0] = '{PIX_CONST, COEF_CONST, 8'sd2, 8'sd3, 16'sd5, 59};
		cases[1] = '{PIX_CONST, COEF_CONST, -8'sd4, 8'sd7, -16'sd100, -352};
		cases[2] = '{PIX_RAMP, COEF_RANDOM, 8'sd0, 8'sd0, 16'sd0, 0};
		cases[3] = '{PIX_RANDOM, COEF_RANDOM, 8'sd0, 8'sd0, 16'sd0, 0};
		cases[4] = '{PIX_CONST, COEF_CONST, 8'h80, 8'h80, 16'h7fff, 180223};
		cases[5] = '{PIX_RANDOM, COEF_CONST, 8'sd0, -8'sd1, 16'sd0, 0};
		cycles = 0;
		do
		begin
			@(posedge clk);
			cycles++;
		end
		while (rst && cycles < 20);
		assert (!rst) else log_timeout("reset release");
		#1;
		assert (!coef_ready) else log_mismatch("coef_ready high after reset");
		// no coefficients yet, so this start must be ignored
		frame_start = 1'b1;
		step_cycle();
		frame_start = 1'b0;
		repeat (20)
		begin
			assert (!pixel_read && !out_valid && !frame_done)
			else log_mismatch("activity before coefficients were loaded");
			step_cycle();
		end
		for (int i = 0; i < N_CASES; i++)
		begin
			load_coefs(cases[i]);
			run_frame(cases[i]);
		end
		$display("closing: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule
